//--- regman.f
+incdir+rtl
rtl/regman_types_pkg.sv
rtl/regman_pipe_pkg.sv
rtl/reg_file.sv
rtl/pending_table.sv
rtl/issue_check.sv
rtl/reg_manage.sv
sim/tb_reg_manage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Done: errors found"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_reg_manage -f regman.f -o tb_reg_manage > "$log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$log"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_reg_manage >> "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "$fail_msg" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi

echo "simulation passed"
exit 0

//--- sim/reg_manage_input.txt
# name req0 rs1 rs2 rd ctx0 req1 rs1 rs2 rd ctx1 wb_v wb_rd wb_data hz hz_ctx rdy0 kill0 d1 d2 rdy1 kill1 d1 d2 lr
# req and rdy are three bits (rs1 rs2 rd), registers in decimal, contexts and data in hex
wr5     000 0 0 0 0     000 0 0 0 0     1 5 a5    0 0  000 0 0 0     000 0 0 0     0
rd5     100 5 0 0 0     000 0 0 0 0     0 0 0     0 0  100 0 a5 0    000 0 0 0     0
wr0     100 0 0 0 0     000 0 0 0 0     1 0 ff    0 0  100 0 0 0     000 0 0 0     0
rd0     110 0 0 0 0     010 0 5 0 0     0 0 0     0 0  110 0 0 0     010 0 0 a5    0
fwd6    100 6 0 0 0     010 0 6 0 0     1 6 66    0 0  100 0 66 0    010 0 0 66    0
claim8  001 0 0 8 1     000 0 0 0 0     0 0 0     0 0  001 0 0 0     000 0 0 0     0
fwdpend 100 8 0 0 0     000 0 0 0 0     1 8 88    0 0  100 0 88 0    000 0 0 0     0
claim7  001 0 0 7 1     000 0 0 0 0     0 0 0     0 0  001 0 0 0     000 0 0 0     0
stall7  110 7 7 0 0     100 7 0 0 0     0 0 0     0 0  000 0 0 0     000 0 0 0     0
stall7b 110 7 7 0 0     100 8 0 0 0     0 0 0     0 0  000 0 0 0     100 0 88 0    0
wb7     110 7 7 0 0     000 0 0 0 0     1 7 77    0 0  110 0 77 77   000 0 0 0     0
rd7     100 7 0 0 0     000 0 0 0 0     0 0 0     0 0  100 0 77 0    000 0 0 0     0
chain9  001 0 0 9 1     101 9 0 9 1     0 0 0     0 0  001 0 0 0     000 0 0 0     0
pend9   100 9 0 0 0     000 0 0 0 0     0 0 0     0 0  000 0 0 0     000 0 0 0     0
chainok 001 0 0 10 2    101 5 0 11 2    0 0 0     0 0  001 0 0 0     101 0 a5 0    0
rdzero  001 0 0 0 2     100 0 0 0 0     0 0 0     0 0  001 0 0 0     100 0 0 0     0
pend10  110 10 11 0 0   100 9 0 0 0     0 0 0     0 0  000 0 0 0     000 0 0 0     0
flush2  111 5 6 12 2    111 10 11 13 1  0 0 0     1 2  000 1 0 0     111 0 0 0     0
after2  110 10 11 0 0   110 9 13 0 0    0 0 0     0 0  110 0 0 0     000 0 0 0     0
other4  100 9 0 0 0     001 0 0 14 4    0 0 0     1 4  000 0 0 0     000 1 0 0     0
flush1  110 9 13 0 0    001 0 0 9 2     0 0 0     1 1  110 0 0 0     001 0 0 0     0
wb9     100 9 0 0 0     000 0 0 0 0     1 9 99    0 0  100 0 99 0    000 0 0 0     0
wrlr    100 1 0 0 0     000 0 0 0 0     1 1 1234  0 0  100 0 1234 0  000 0 0 0     0
lr1     000 0 0 0 0     010 0 1 0 0     0 0 0     0 0  000 0 0 0     010 0 0 1234  1234
wrlr2   000 0 0 0 0     000 0 0 0 0     1 1 beef  0 0  000 0 0 0     000 0 0 0     1234
wr2     000 0 0 0 0     000 0 0 0 0     1 2 2222  0 0  000 0 0 0     000 0 0 0     beef
claimlr 001 0 0 1 1     000 0 0 0 0     0 0 0     0 0  001 0 0 0     000 0 0 0     beef
lrpend  100 1 0 0 0     000 0 0 0 0     0 0 0     0 0  000 0 0 0     000 0 0 0     beef
lrflush 100 1 0 0 0     000 0 0 0 0     0 0 0     1 1  100 0 beef 0  000 0 0 0     beef
rd2     110 2 9 0 0     000 0 0 0 0     0 0 0     0 0  110 0 2222 99 000 0 0 0     beef
idle    000 0 0 0 0     000 0 0 0 0     0 0 0     0 0  000 0 0 0     000 0 0 0     beef

//--- sim/tb_reg_manage.sv
`timescale 1ns/10ps
`default_nettype none

`include "regman_macros.svh"

module tb_reg_manage
    import regman_types_pkg::*;
    import regman_pipe_pkg::*;
();

    // one line of the vector file
    typedef struct packed {
        logic [127:0]       name;
        issue_req_t [1:0]   req;
        wb_t                wb;
        logic               hazard;
        context_t           hazard_ctx;
        issue_grant_t [1:0] exp;
        word_t              lr;
    } vector_t;

    localparam int RESET_CYCLES = 8;
    localparam int SPARE_CYCLES = 20;

    logic         clk;
    logic         rst_n;
    issue_req_t   issue_req [`INST_W_PARA];
    issue_grant_t issue_grant [`INST_W_PARA];
    wb_t          writeback;
    logic         branch_hazard;
    context_t     hazard_context;
    word_t        lr_data;

    vector_t vectors [$];
    int      error_count;
    int      cycle_count;
    int      cycle_limit = RESET_CYCLES + SPARE_CYCLES;

    reg_manage DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_req      (issue_req),
        .issue_grant    (issue_grant),
        .writeback      (writeback),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .lr_data        (lr_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // request flags in the file are ordered rs1, rs2, rd
    function automatic issue_req_t make_req(input logic [2:0] flags, input int src1,
                                            input int src2, input int dst,
                                            input logic [31:0] ctx);
        issue_req_t req;
        req.rs1_req = flags[2];
        req.rs1     = reg_addr_t'(src1);
        req.rs2_req = flags[1];
        req.rs2     = reg_addr_t'(src2);
        req.rd_req  = flags[0];
        req.rd      = reg_addr_t'(dst);
        req.ctx     = context_t'(ctx);
        return req;
    endfunction

    // granted rd always echoes the requested rd, renaming is identity
    function automatic issue_grant_t make_grant(input logic [2:0] flags, input int kill,
                                                input word_t data1, input word_t data2,
                                                input int dst);
        issue_grant_t grant;
        grant.rs1_ready = flags[2];
        grant.rs1_data  = data1;
        grant.rs2_ready = flags[1];
        grant.rs2_data  = data2;
        grant.rd_ready  = flags[0];
        grant.rd        = reg_addr_t'(dst);
        grant.killed    = (kill != 0);
        return grant;
    endfunction

    task automatic load_vectors();
        int           fd;
        int           count;
        int           line_no;
        string        line;
        byte          first;
        logic [127:0] name;
        logic [2:0]   req0_bits;
        logic [2:0]   req1_bits;
        logic [2:0]   rdy0_bits;
        logic [2:0]   rdy1_bits;
        int           src0_a;
        int           src0_b;
        int           dst0;
        int           src1_a;
        int           src1_b;
        int           dst1;
        int           wb_valid;
        int           wb_reg;
        int           hazard;
        int           kill0;
        int           kill1;
        logic [31:0]  ctx0;
        logic [31:0]  ctx1;
        logic [31:0]  wb_data;
        logic [31:0]  hazard_mask;
        logic [31:0]  exp0_a;
        logic [31:0]  exp0_b;
        logic [31:0]  exp1_a;
        logic [31:0]  exp1_b;
        logic [31:0]  exp_lr;
        vector_t      v;

        fd = $fopen("sim/reg_manage_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/reg_manage_input.txt");
            error_count++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            line_no++;
            if (count == 0 || line.len() == 0) begin
                continue;
            end
            first = line.getc(0);
            // comment and blank lines
            if (first == "#" || first == "\n") begin
                continue;
            end
            count = $sscanf(line,
                "%s %b %d %d %d %h %b %d %d %d %h %d %d %h %d %h %b %d %h %h %b %d %h %h %h",
                name, req0_bits, src0_a, src0_b, dst0, ctx0,
                req1_bits, src1_a, src1_b, dst1, ctx1,
                wb_valid, wb_reg, wb_data, hazard, hazard_mask,
                rdy0_bits, kill0, exp0_a, exp0_b, rdy1_bits, kill1, exp1_a, exp1_b, exp_lr);
            if (count != 25) begin
                $display("vector file line %0d is malformed", line_no);
                error_count++;
                continue;
            end
            v.name       = name;
            v.req[0]     = make_req(req0_bits, src0_a, src0_b, dst0, ctx0);
            v.req[1]     = make_req(req1_bits, src1_a, src1_b, dst1, ctx1);
            v.wb.valid   = (wb_valid != 0);
            v.wb.rd      = reg_addr_t'(wb_reg);
            v.wb.data    = wb_data;
            v.hazard     = (hazard != 0);
            v.hazard_ctx = context_t'(hazard_mask);
            v.exp[0]     = make_grant(rdy0_bits, kill0, exp0_a, exp0_b, dst0);
            v.exp[1]     = make_grant(rdy1_bits, kill1, exp1_a, exp1_b, dst1);
            v.lr         = exp_lr;
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("no test vectors were loaded");
            error_count++;
        end
    endtask

    task automatic clear_inputs();
        for (int s = 0; s < `INST_W_PARA; s++) begin
            issue_req[s] = '0;
        end
        writeback      = '0;
        branch_hazard  = 1'b0;
        hazard_context = '0;
    endtask

    task automatic apply_vector(input vector_t v);
        for (int s = 0; s < `INST_W_PARA; s++) begin
            issue_req[s] = v.req[s];
        end
        writeback      = v.wb;
        branch_hazard  = v.hazard;
        hazard_context = v.hazard_ctx;
    endtask

    task automatic match_bit(input logic [127:0] test, input string field,
                             input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("ERR %0s %0s: expected %0b, actual %0b", test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_word(input logic [127:0] test, input string field,
                                input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("ERR %0s %0s: expected %0h, actual %0h", test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_outputs(input vector_t v);
        issue_grant_t got;
        issue_grant_t want;
        for (int s = 0; s < `INST_W_PARA; s++) begin
            got  = issue_grant[s];
            want = v.exp[s];
            match_bit(v.name, $sformatf("slot%0d killed", s), want.killed, got.killed);
            match_bit(v.name, $sformatf("slot%0d rs1_ready", s), want.rs1_ready,
                      got.rs1_ready);
            match_bit(v.name, $sformatf("slot%0d rs2_ready", s), want.rs2_ready,
                      got.rs2_ready);
            match_bit(v.name, $sformatf("slot%0d rd_ready", s), want.rd_ready,
                      got.rd_ready);
            compare_word(v.name, $sformatf("slot%0d rd", s), word_t'(want.rd),
                         word_t'(got.rd));
            // operand data only means something once granted
            if (want.rs1_ready) begin
                compare_word(v.name, $sformatf("slot%0d rs1_data", s), want.rs1_data,
                             got.rs1_data);
            end
            if (want.rs2_ready) begin
                compare_word(v.name, $sformatf("slot%0d rs2_data", s), want.rs2_data,
                             got.rs2_data);
            end
        end
        compare_word(v.name, "lr_data", v.lr, lr_data);
    endtask

    initial begin
        rst_n = 1'b0;
        clear_inputs();
        error_count = 0;
        load_vectors();
        cycle_limit = RESET_CYCLES + vectors.size() + SPARE_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // grants are combinational, so check well before the rising edge
        foreach (vectors[i]) begin
            @(negedge clk);
            apply_vector(vectors[i]);
            #1;
            check_outputs(vectors[i]);
        end
        @(negedge clk);
        clear_inputs();

        $display("vectors run: %0d, errors: %0d", vectors.size(), error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles, %0d errors so far",
                 cycle_limit, error_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/reg_manage.sv
`timescale 1ns/10ps
`default_nettype none

`include "regman_macros.svh"

module reg_manage
    import regman_types_pkg::*;
    import regman_pipe_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire issue_req_t issue_req [`INST_W_PARA],
    output issue_grant_t    issue_grant [`INST_W_PARA],
    input  wire wb_t        writeback,
    input  wire             branch_hazard,
    input  wire context_t   hazard_context,
    output word_t           lr_data
);

    // register file read path
    reg_addr_t rf_addr [`INST_W_PARA][2];
    word_t     rf_data [`INST_W_PARA][2];

    // pending table to issue check
    context_t live_context [NUM_REGS];

    // claims back into the pending table
    logic [`INST_W_PARA-1:0] claim_valid;
    reg_addr_t               claim_reg [`INST_W_PARA];
    context_t                claim_context [`INST_W_PARA];

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr   (rf_addr),
        .rd_data   (rf_data),
        .lr_data   (lr_data),
        .writeback (writeback)
    );

    pending_table u_pending_table (
        .clk            (clk),
        .rst_n          (rst_n),
        .writeback      (writeback),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .claim_valid    (claim_valid),
        .claim_reg      (claim_reg),
        .claim_context  (claim_context),
        .live_context   (live_context)
    );

    issue_check u_issue_check (
        .issue_req      (issue_req),
        .issue_grant    (issue_grant),
        .live_context   (live_context),
        .writeback      (writeback),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .rf_addr        (rf_addr),
        .rf_data        (rf_data),
        .claim_valid    (claim_valid),
        .claim_reg      (claim_reg),
        .claim_context  (claim_context)
    );

endmodule

`default_nettype wire

//--- rtl/issue_check.sv
`timescale 1ns/10ps
`default_nettype none

`include "regman_macros.svh"

module issue_check
    import regman_types_pkg::*;
    import regman_pipe_pkg::*;
(
    input  wire issue_req_t        issue_req [`INST_W_PARA],
    output issue_grant_t           issue_grant [`INST_W_PARA],
    input  wire context_t          live_context [NUM_REGS],
    input  wire wb_t               writeback,
    input  wire                    branch_hazard,
    input  wire context_t          hazard_context,
    output reg_addr_t              rf_addr [`INST_W_PARA][2],
    input  wire word_t             rf_data [`INST_W_PARA][2],
    output logic [`INST_W_PARA-1:0] claim_valid,
    output reg_addr_t              claim_reg [`INST_W_PARA],
    output context_t               claim_context [`INST_W_PARA]
);

    // pending view seen by each slot
    // slot s sees the live table plus claims of slots below it
    context_t view [`INST_W_PARA][NUM_REGS];

    // result on the writeback bus beats the stored value
    function automatic word_t forward(input wb_t wb, input reg_addr_t addr,
                                      input word_t rf_value);
        word_t result;
        result = rf_value;
        if (wb.valid && wb.rd == addr && addr != '0) begin
            result = wb.data;
        end
        return result;
    endfunction

    // source addresses straight from the request
    always_comb begin
        for (int s = 0; s < `INST_W_PARA; s++) begin
            rf_addr[s][0] = issue_req[s].rs1;
            rf_addr[s][1] = issue_req[s].rs2;
        end
    end

    always_comb begin
        for (int r = 0; r < NUM_REGS; r++) begin
            view[0][r] = live_context[r];
        end

        for (int s = 0; s < `INST_W_PARA; s++) begin
            issue_grant[s].killed = branch_hazard
                                    && |(issue_req[s].ctx & hazard_context);

            // sources
            issue_grant[s].rs1_ready = issue_req[s].rs1_req
                                       && view[s][issue_req[s].rs1] == CONTEXT_ZERO
                                       && !issue_grant[s].killed;
            issue_grant[s].rs1_data  = forward(writeback, issue_req[s].rs1,
                                               rf_data[s][0]);
            issue_grant[s].rs2_ready = issue_req[s].rs2_req
                                       && view[s][issue_req[s].rs2] == CONTEXT_ZERO
                                       && !issue_grant[s].killed;
            issue_grant[s].rs2_data  = forward(writeback, issue_req[s].rs2,
                                               rf_data[s][1]);

            // destination, identity rename
            issue_grant[s].rd_ready = issue_req[s].rd_req
                                      && view[s][issue_req[s].rd] == CONTEXT_ZERO
                                      && !issue_grant[s].killed;
            issue_grant[s].rd       = issue_req[s].rd;

            // a granted destination becomes a claim
            claim_valid[s]   = issue_grant[s].rd_ready;
            claim_reg[s]     = issue_req[s].rd;
            claim_context[s] = issue_req[s].ctx;

            // hand the updated view to the next slot
            if (s + 1 < `INST_W_PARA) begin
                view[s+1][0] = CONTEXT_ZERO;
                for (int r = 1; r < NUM_REGS; r++) begin
                    if (claim_valid[s] && claim_reg[s] == reg_addr_t'(r)) begin
                        view[s+1][r] = claim_context[s];
                    end else begin
                        view[s+1][r] = view[s][r];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pending_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "regman_macros.svh"

module pending_table
    import regman_types_pkg::*;
    import regman_pipe_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire wb_t               writeback,
    input  wire                    branch_hazard,
    input  wire context_t          hazard_context,
    input  wire [`INST_W_PARA-1:0] claim_valid,
    input  wire reg_addr_t         claim_reg [`INST_W_PARA],
    input  wire context_t          claim_context [`INST_W_PARA],
    output context_t               live_context [NUM_REGS]
);

    // owner context per register, as of the last edge
    context_t owner_q [NUM_REGS];
    // value taken at the next edge
    context_t owner_d [NUM_REGS];

    // live view after this cycle's writeback and flush
    always_comb begin
        for (int r = 0; r < NUM_REGS; r++) begin
            live_context[r] = owner_q[r];
            // result has arrived, register is free again
            if (writeback.valid && writeback.rd == reg_addr_t'(r)) begin
                live_context[r] = CONTEXT_ZERO;
            end
            // owner was on the wrong path
            if (branch_hazard && |(owner_q[r] & hazard_context)) begin
                live_context[r] = CONTEXT_ZERO;
            end
        end
    end

    // claims granted this cycle land on top of the live view
    always_comb begin
        for (int r = 0; r < NUM_REGS; r++) begin
            owner_d[r] = live_context[r];
            // later slot wins when both claim one register
            for (int s = 0; s < `INST_W_PARA; s++) begin
                if (claim_valid[s] && claim_reg[s] == reg_addr_t'(r)) begin
                    owner_d[r] = claim_context[s];
                end
            end
        end
        // register zero never waits
        owner_d[0] = CONTEXT_ZERO;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                owner_q[r] <= CONTEXT_ZERO;
            end
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                owner_q[r] <= owner_d[r];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "regman_macros.svh"

module reg_file
    import regman_types_pkg::*;
    import regman_pipe_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t rd_addr [`INST_W_PARA][2],
    output word_t          rd_data [`INST_W_PARA][2],
    output word_t          lr_data,
    input  wire wb_t       writeback
);

    // register zero has no storage behind it
    word_t regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs_q[r] <= WORD_ZERO;
            end
        end else if (writeback.valid && writeback.rd != '0) begin
            regs_q[writeback.rd] <= writeback.data;
        end
    end

    // two source ports per slot, asynchronous read
    always_comb begin
        for (int s = 0; s < `INST_W_PARA; s++) begin
            for (int p = 0; p < 2; p++) begin
                if (rd_addr[s][p] == '0) begin
                    rd_data[s][p] = WORD_ZERO;
                end else begin
                    rd_data[s][p] = regs_q[rd_addr[s][p]];
                end
            end
        end
    end

    // link register, always visible
    assign lr_data = regs_q[`LR_INDEX];

endmodule

`default_nettype wire

//--- rtl/regman_pipe_pkg.sv
`default_nettype none

package regman_pipe_pkg;

    import regman_types_pkg::*;

    // request from decode for one slot
    typedef struct packed {
        logic      rs1_req;
        reg_addr_t rs1;
        logic      rs2_req;
        reg_addr_t rs2;
        logic      rd_req;
        reg_addr_t rd;
        // branch context the instruction was issued under
        context_t  ctx;
    } issue_req_t;

    // answer to decode for one slot
    typedef struct packed {
        logic      rs1_ready;
        word_t     rs1_data;
        logic      rs2_ready;
        word_t     rs2_data;
        logic      rd_ready;
        reg_addr_t rd;
        // request belongs to a mispredicted context
        logic      killed;
    } issue_grant_t;

    // result coming back from execute
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

//--- rtl/regman_types_pkg.sv
`default_nettype none

`include "regman_macros.svh"

package regman_types_pkg;

    // one data word
    typedef logic [`LEN_WORD-1:0] word_t;

    // architectural register number, renaming is identity
    typedef logic [`LEN_REG_ADDR-1:0] reg_addr_t;

    // one-hot speculative branch context
    // zero means the register is not waiting on anything
    typedef logic [`LEN_CONTEXT-1:0] context_t;

    // number of architectural registers
    localparam int unsigned NUM_REGS = 2 ** `LEN_REG_ADDR;

    localparam context_t CONTEXT_ZERO = '0;
    localparam word_t WORD_ZERO = '0;

endpackage

`default_nettype wire

//--- rtl/regman_macros.svh
`ifndef REGMAN_MACROS_SVH
`define REGMAN_MACROS_SVH

// width of one data word
`define LEN_WORD 32

// register number width, 32 registers
`define LEN_REG_ADDR 5

// decoded instructions offered per cycle
`define INST_W_PARA 2

// one-hot branch context mask
`define LEN_CONTEXT 4

// register read out continuously as the link register
`define LR_INDEX 1

`endif
